// File: rtl/cp0_cfg.svh
`ifndef CP0_CFG_SVH
`define CP0_CFG_SVH

// CP0 register numbers, one per Wishbone word address
`define CP0_INDEX     5'd0
`define CP0_ENTRYLO0  5'd2
`define CP0_ENTRYLO1  5'd3
`define CP0_BADVADDR  5'd8
`define CP0_COUNT     5'd9
`define CP0_ENTRYHI   5'd10
`define CP0_COMPARE   5'd11
`define CP0_STATUS    5'd12
`define CP0_CAUSE     5'd13
`define CP0_EPC       5'd14
`define CP0_EBASE     5'd15

`define TLB_ENTRIES   16
`define TLB_IDX_W     4

// status comes out of reset in user mode with EXL and IE clear
`define STATUS_RESET  32'h00000010
`define EBASE_RESET   32'h80000000

`define ST_UM         4
`define ST_EXL        1
`define ST_IE         0
`define CAUSE_SW_MSB  9
`define CAUSE_SW_LSB  8
`define EBASE_MSB     29
`define EBASE_LSB     12
`define VPN2_MSB      31
`define VPN2_LSB      13
`define PFN_MSB       29
`define PFN_LSB       6
`define PTE_D         2
`define PTE_V         1
`define FLAG_D        1
`define FLAG_V        0
`define PAGE_SEL      12
`define EXC_VEC_OFF   12'h180

`endif

// File: rtl/cp0_pkg.sv
`include "cp0_cfg.svh"

package cp0_pkg;

    // register data and virtual addresses
    typedef logic [31:0] word_t;

    typedef logic [4:0] reg_addr_t;

    // virtual page-pair number, vaddr[31:13]
    typedef logic [18:0] vpn2_t;

    typedef logic [23:0] pfn_t;

    // dirty in bit 1, valid in bit 0
    typedef logic [1:0] pte_flags_t;

    typedef logic [`TLB_IDX_W-1:0] tlb_idx_t;

    // pfn followed by the 12-bit page offset
    typedef logic [35:0] paddr_t;

    typedef logic [4:0] exc_code_t;

    // two-state classic slave, ack is high only in WB_ACK
    typedef enum logic {
        WB_IDLE,
        WB_ACK
    } wb_state_t;

endpackage

// File: rtl/tlb_wr_if.sv
`timescale 1ns/1ns

interface tlb_wr_if
    import cp0_pkg::*;
();
    logic       wr_en;
    tlb_idx_t   wr_idx;
    vpn2_t      vpn2;
    pfn_t       pfn0;
    pte_flags_t flags0;
    pfn_t       pfn1;
    pte_flags_t flags1;

    // the register file drives, every entry listens
    modport src (output wr_en, wr_idx, vpn2, pfn0, flags0, pfn1, flags1);
    modport snk (input wr_en, wr_idx, vpn2, pfn0, flags0, pfn1, flags1);

endinterface

// File: rtl/cp0_regfile.sv
`timescale 1ns/1ns
`include "cp0_cfg.svh"

module cp0_regfile
    import cp0_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       wb_cyc_i,
    input  logic       wb_stb_i,
    input  logic       wb_we_i,
    input  reg_addr_t  wb_adr_i,
    input  word_t      wb_dat_i,
    output word_t      wb_dat_o,
    output logic       wb_ack_o,
    input  logic [5:0] hw_int_i,
    input  logic       exc_i,
    input  word_t      exc_epc_i,
    input  logic       exc_bd_i,
    input  exc_code_t  exc_code_i,
    input  word_t      exc_badvaddr_i,
    input  logic       eret_i,
    input  logic       tlbwi_i,
    output logic       irq_o,
    output logic       user_mode_o,
    output word_t      exc_vector_o,
    tlb_wr_if.src      wr
);
    localparam word_t STATUS_INIT = `STATUS_RESET;
    localparam word_t EBASE_INIT  = `EBASE_RESET;

    wb_state_t                   state_q;
    logic                        wr_fire;
    logic                        wr_en_q;
    word_t                       count_q;
    word_t                       compare_q;
    logic                        timer_int_q;
    logic                        um_q;
    logic                        exl_q;
    logic                        ie_q;
    logic [`EBASE_MSB:`EBASE_LSB] ebase_q;
    logic [1:0]                  soft_q;
    logic                        bd_q;
    exc_code_t                   code_q;
    word_t                       epc_q;
    word_t                       badvaddr_q;
    tlb_idx_t                    index_q;
    vpn2_t                       vpn2_q;
    pfn_t                        pfn0_q;
    pfn_t                        pfn1_q;
    pte_flags_t                  flags0_q;
    pte_flags_t                  flags1_q;

    // writes land on the same edge that moves the slave into WB_ACK
    assign wr_fire  = (state_q == WB_IDLE) && wb_cyc_i && wb_stb_i && wb_we_i;
    assign wb_ack_o = (state_q == WB_ACK);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= WB_IDLE;
            wr_en_q <= 1'b0;
        end else begin
            wr_en_q <= tlbwi_i;
            if (state_q == WB_IDLE && wb_cyc_i && wb_stb_i) begin
                state_q <= WB_ACK;
            end else begin
                state_q <= WB_IDLE;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count_q     <= '0;
            compare_q   <= '0;
            timer_int_q <= 1'b0;
            um_q        <= STATUS_INIT[`ST_UM];
            exl_q       <= STATUS_INIT[`ST_EXL];
            ie_q        <= STATUS_INIT[`ST_IE];
            ebase_q     <= EBASE_INIT[`EBASE_MSB:`EBASE_LSB];
            soft_q      <= '0;
            bd_q        <= 1'b0;
            code_q      <= '0;
        end else begin
            count_q <= count_q + 32'd1;
            if (compare_q != '0 && compare_q == count_q) begin
                timer_int_q <= 1'b1;
            end
            if (wr_fire) begin
                case (wb_adr_i)
                    `CP0_COUNT: count_q <= wb_dat_i;
                    `CP0_COMPARE: begin
                        compare_q   <= wb_dat_i;
                        timer_int_q <= 1'b0;
                    end
                    `CP0_STATUS: begin
                        um_q  <= wb_dat_i[`ST_UM];
                        exl_q <= wb_dat_i[`ST_EXL];
                        ie_q  <= wb_dat_i[`ST_IE];
                    end
                    `CP0_CAUSE: soft_q <= wb_dat_i[`CAUSE_SW_MSB:`CAUSE_SW_LSB];
                    `CP0_EBASE: ebase_q <= wb_dat_i[`EBASE_MSB:`EBASE_LSB];
                    default: ;
                endcase
            end
            if (eret_i) begin
                exl_q <= 1'b0;
            end
            // exception entry comes last so it overrides a host write
            if (exc_i) begin
                exl_q  <= 1'b1;
                bd_q   <= exc_bd_i;
                code_q <= exc_code_i;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            case (wb_adr_i)
                `CP0_INDEX: index_q <= wb_dat_i[`TLB_IDX_W-1:0];
                `CP0_ENTRYHI: vpn2_q <= wb_dat_i[`VPN2_MSB:`VPN2_LSB];
                `CP0_ENTRYLO0: begin
                    pfn0_q   <= wb_dat_i[`PFN_MSB:`PFN_LSB];
                    flags0_q <= wb_dat_i[`PTE_D:`PTE_V];
                end
                `CP0_ENTRYLO1: begin
                    pfn1_q   <= wb_dat_i[`PFN_MSB:`PFN_LSB];
                    flags1_q <= wb_dat_i[`PTE_D:`PTE_V];
                end
                `CP0_EPC: epc_q <= wb_dat_i;
                default: ;
            endcase
        end
        if (exc_i) begin
            epc_q      <= exc_epc_i;
            badvaddr_q <= exc_badvaddr_i;
        end
    end

    always_comb begin
        case (wb_adr_i)
            `CP0_INDEX:    wb_dat_o = {{(32 - `TLB_IDX_W){1'b0}}, index_q};
            `CP0_ENTRYLO0: wb_dat_o = {2'b0, pfn0_q, 3'b0, flags0_q, 1'b0};
            `CP0_ENTRYLO1: wb_dat_o = {2'b0, pfn1_q, 3'b0, flags1_q, 1'b0};
            `CP0_BADVADDR: wb_dat_o = badvaddr_q;
            `CP0_COUNT:    wb_dat_o = count_q;
            `CP0_ENTRYHI:  wb_dat_o = {vpn2_q, 13'b0};
            `CP0_COMPARE:  wb_dat_o = compare_q;
            `CP0_STATUS:   wb_dat_o = {27'b0, um_q, 2'b0, exl_q, ie_q};
            // the timer shares IP7 with the top hardware line
            `CP0_CAUSE: begin
                wb_dat_o = {bd_q, 15'b0, hw_int_i | {timer_int_q, 5'b0},
                            soft_q, 1'b0, code_q, 2'b0};
            end
            `CP0_EPC:      wb_dat_o = epc_q;
            `CP0_EBASE:    wb_dat_o = {2'b10, ebase_q, 12'b0};
            default:       wb_dat_o = '0;
        endcase
    end

    assign irq_o        = ie_q && !exl_q && (|hw_int_i || |soft_q || timer_int_q);
    assign user_mode_o  = um_q;
    assign exc_vector_o = {2'b10, ebase_q, `EXC_VEC_OFF};

    assign wr.wr_en  = wr_en_q;
    assign wr.wr_idx = index_q;
    assign wr.vpn2   = vpn2_q;
    assign wr.pfn0   = pfn0_q;
    assign wr.flags0 = flags0_q;
    assign wr.pfn1   = pfn1_q;
    assign wr.flags1 = flags1_q;

endmodule

// File: rtl/tlb_entry.sv
`timescale 1ns/1ns

module tlb_entry
    import cp0_pkg::*;
#(
    parameter int ENTRY_ID = 0
) (
    input  logic       clk,
    input  logic       rst_n,
    tlb_wr_if.snk      wr,
    input  vpn2_t      lookup_vpn2_i,
    output logic       match_o,
    output pfn_t       pfn0_o,
    output pfn_t       pfn1_o,
    output pte_flags_t flags0_o,
    output pte_flags_t flags1_o
);
    logic  sel;
    logic  written_q;
    vpn2_t vpn2_q;

    assign sel = wr.wr_en && (wr.wr_idx == tlb_idx_t'(ENTRY_ID));

    // an entry only takes part in lookups once software has written it
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            written_q <= 1'b0;
        end else if (sel) begin
            written_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (sel) begin
            vpn2_q   <= wr.vpn2;
            pfn0_o   <= wr.pfn0;
            flags0_o <= wr.flags0;
            pfn1_o   <= wr.pfn1;
            flags1_o <= wr.flags1;
        end
    end

    assign match_o = written_q && (vpn2_q == lookup_vpn2_i);

endmodule

// File: rtl/tlb_translate.sv
`timescale 1ns/1ns
`include "cp0_cfg.svh"

module tlb_translate
    import cp0_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    req_i,
    input  word_t                   vaddr_i,
    input  logic [`TLB_ENTRIES-1:0] match_i,
    input  pfn_t                    pfn0_i [`TLB_ENTRIES],
    input  pfn_t                    pfn1_i [`TLB_ENTRIES],
    input  pte_flags_t              flags0_i [`TLB_ENTRIES],
    input  pte_flags_t              flags1_i [`TLB_ENTRIES],
    output logic                    valid_o,
    output paddr_t                  paddr_o,
    output logic                    hit_o,
    output logic                    page_valid_o,
    output logic                    dirty_o
);
    tlb_idx_t   sel;
    logic       any_hit;
    logic       odd_page;
    pfn_t       sel_pfn;
    pte_flags_t sel_flags;

    // scanning downwards leaves the lowest matching index in sel
    always_comb begin
        sel = '0;
        for (int i = `TLB_ENTRIES - 1; i >= 0; i--) begin
            if (match_i[i]) begin
                sel = tlb_idx_t'(i);
            end
        end
    end

    assign any_hit   = |match_i;
    assign odd_page  = vaddr_i[`PAGE_SEL];
    assign sel_pfn   = odd_page ? pfn1_i[sel] : pfn0_i[sel];
    assign sel_flags = odd_page ? flags1_i[sel] : flags0_i[sel];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_o      <= 1'b0;
            hit_o        <= 1'b0;
            page_valid_o <= 1'b0;
            dirty_o      <= 1'b0;
        end else begin
            valid_o <= req_i;
            if (req_i) begin
                hit_o        <= any_hit;
                page_valid_o <= any_hit && sel_flags[`FLAG_V];
                dirty_o      <= any_hit && sel_flags[`FLAG_D];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_i) begin
            paddr_o <= any_hit ? {sel_pfn, vaddr_i[`PAGE_SEL-1:0]} : '0;
        end
    end

endmodule

// File: rtl/mmu_cp0_top.sv
`timescale 1ns/1ns
`include "cp0_cfg.svh"

module mmu_cp0_top
    import cp0_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       wb_cyc_i,
    input  logic       wb_stb_i,
    input  logic       wb_we_i,
    input  reg_addr_t  wb_adr_i,
    input  word_t      wb_dat_i,
    output word_t      wb_dat_o,
    output logic       wb_ack_o,
    input  logic [5:0] hw_int_i,
    input  logic       exc_i,
    input  word_t      exc_epc_i,
    input  logic       exc_bd_i,
    input  exc_code_t  exc_code_i,
    input  word_t      exc_badvaddr_i,
    input  logic       eret_i,
    input  logic       tlbwi_i,
    output logic       irq_o,
    output logic       user_mode_o,
    output word_t      exc_vector_o,
    input  logic       xlat_req_i,
    input  word_t      xlat_vaddr_i,
    output logic       xlat_valid_o,
    output paddr_t     xlat_paddr_o,
    output logic       xlat_hit_o,
    output logic       xlat_page_valid_o,
    output logic       xlat_dirty_o
);
    logic [`TLB_ENTRIES-1:0] match;
    pfn_t                    pfn0 [`TLB_ENTRIES];
    pfn_t                    pfn1 [`TLB_ENTRIES];
    pte_flags_t              flags0 [`TLB_ENTRIES];
    pte_flags_t              flags1 [`TLB_ENTRIES];

    tlb_wr_if wr_bus ();

    cp0_regfile u_regfile (
        .clk            (clk),
        .rst_n          (rst_n),
        .wb_cyc_i       (wb_cyc_i),
        .wb_stb_i       (wb_stb_i),
        .wb_we_i        (wb_we_i),
        .wb_adr_i       (wb_adr_i),
        .wb_dat_i       (wb_dat_i),
        .wb_dat_o       (wb_dat_o),
        .wb_ack_o       (wb_ack_o),
        .hw_int_i       (hw_int_i),
        .exc_i          (exc_i),
        .exc_epc_i      (exc_epc_i),
        .exc_bd_i       (exc_bd_i),
        .exc_code_i     (exc_code_i),
        .exc_badvaddr_i (exc_badvaddr_i),
        .eret_i         (eret_i),
        .tlbwi_i        (tlbwi_i),
        .irq_o          (irq_o),
        .user_mode_o    (user_mode_o),
        .exc_vector_o   (exc_vector_o),
        .wr             (wr_bus.src)
    );

    // every entry compares against the page pair of the current request
    for (genvar g = 0; g < `TLB_ENTRIES; g++) begin : g_entry
        tlb_entry #(
            .ENTRY_ID (g)
        ) u_entry (
            .clk           (clk),
            .rst_n         (rst_n),
            .wr            (wr_bus.snk),
            .lookup_vpn2_i (xlat_vaddr_i[`VPN2_MSB:`VPN2_LSB]),
            .match_o       (match[g]),
            .pfn0_o        (pfn0[g]),
            .pfn1_o        (pfn1[g]),
            .flags0_o      (flags0[g]),
            .flags1_o      (flags1[g])
        );
    end

    tlb_translate u_translate (
        .clk          (clk),
        .rst_n        (rst_n),
        .req_i        (xlat_req_i),
        .vaddr_i      (xlat_vaddr_i),
        .match_i      (match),
        .pfn0_i       (pfn0),
        .pfn1_i       (pfn1),
        .flags0_i     (flags0),
        .flags1_i     (flags1),
        .valid_o      (xlat_valid_o),
        .paddr_o      (xlat_paddr_o),
        .hit_o        (xlat_hit_o),
        .page_valid_o (xlat_page_valid_o),
        .dirty_o      (xlat_dirty_o)
    );

endmodule

// File: verification/mmu_cp0_assert.sv
`timescale 1ns/1ns

module mmu_cp0_assert (
    input logic clk,
    input logic rst_n,
    input logic cyc_i,
    input logic stb_i,
    input logic ack_i,
    input logic exc_i,
    input logic irq_i,
    input logic xlat_req_i,
    input logic xlat_valid_i
);
    // ack only answers a request that the slave saw while idle
    ack_follows_req: assert property (@(posedge clk) disable iff (!rst_n)
        ack_i |-> $past(cyc_i && stb_i && !ack_i))
        else $error("wb_ack_o rose without a request");

    ack_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        ack_i |=> !ack_i)
        else $error("wb_ack_o held for more than one cycle");

    // exception entry sets EXL, which masks every pending source
    irq_masked_after_exc: assert property (@(posedge clk) disable iff (!rst_n)
        exc_i |=> !irq_i)
        else $error("irq_o high on the cycle after an exception");

    xlat_valid_follows_req: assert property (@(posedge clk) disable iff (!rst_n)
        xlat_valid_i == $past(xlat_req_i))
        else $error("xlat_valid_o does not follow xlat_req_i by one cycle");

endmodule

bind mmu_cp0_top mmu_cp0_assert u_assert (
    .clk          (clk),
    .rst_n        (rst_n),
    .cyc_i        (wb_cyc_i),
    .stb_i        (wb_stb_i),
    .ack_i        (wb_ack_o),
    .exc_i        (exc_i),
    .irq_i        (irq_o),
    .xlat_req_i   (xlat_req_i),
    .xlat_valid_i (xlat_valid_o)
);

// File: verification/mmu_cp0_tb.sv
`timescale 1ns/1ns
`include "cp0_cfg.svh"

module mmu_cp0_tb
    import cp0_pkg::*;
();
    localparam int REG_N = 14;
    localparam int TLB_N = 6;
    localparam int LOOKUPS = 40;
    localparam int WATCHDOG_CYCLES = (REG_N + TLB_N) * 20 + 2000;

    // register, write value, expected read-back
    localparam logic [68:0] REG_TAB [REG_N] = '{
        {`CP0_INDEX,    32'hFFFFFFF5, 32'h00000005},
        {`CP0_ENTRYHI,  32'hFFFFFFFF, 32'hFFFFE000},
        {`CP0_ENTRYLO0, 32'hFFFFFFFF, 32'h3FFFFFC6},
        {`CP0_ENTRYLO1, 32'h12345678, 32'h12345640},
        {`CP0_COMPARE,  32'hA5A5A5A5, 32'hA5A5A5A5},
        {`CP0_EPC,      32'hDEADBEEF, 32'hDEADBEEF},
        {`CP0_EBASE,    32'hFFFFFFFF, 32'hBFFFF000},
        {`CP0_EBASE,    32'h12345678, 32'h92345000},
        {`CP0_STATUS,   32'hFFFFFFFF, 32'h00000013},
        {`CP0_STATUS,   32'h00000010, 32'h00000010},
        {`CP0_CAUSE,    32'hFFFFFFFF, 32'h00000300},
        {`CP0_CAUSE,    32'h00000000, 32'h00000000},
        {5'd1,          32'hFFFFFFFF, 32'h00000000},
        {5'd20,         32'h12345678, 32'h00000000}
    };

    // index, vpn2, pfn0, flags0, pfn1, flags1 (flags are dirty then valid)
    localparam logic [74:0] TLB_TAB [TLB_N] = '{
        {4'd0,  19'h00001, 24'h000100, 2'b01, 24'h000101, 2'b11},
        {4'd3,  19'h12345, 24'hABCDEF, 2'b11, 24'h123456, 2'b00},
        {4'd7,  19'h7FFFF, 24'hFFFFFF, 2'b10, 24'h000000, 2'b01},
        {4'd9,  19'h12345, 24'h999999, 2'b00, 24'h888888, 2'b11},
        {4'd12, 19'h2ABCD, 24'h0F0F0F, 2'b01, 24'hF0F0F0, 2'b01},
        {4'd15, 19'h40000, 24'h555555, 2'b11, 24'hAAAAAA, 2'b10}
    };

    logic       clk, rst_n;
    logic       wb_cyc, wb_stb, wb_we, wb_ack;
    reg_addr_t  wb_adr;
    word_t      wb_dat_w, wb_dat_r;
    logic [5:0] hw_int;
    logic       exc, exc_bd, eret, tlbwi, irq, user_mode;
    word_t      exc_epc, exc_badvaddr, exc_vector;
    exc_code_t  exc_code;
    logic       xlat_req, xlat_valid, xlat_hit, xlat_page_valid, xlat_dirty;
    word_t      xlat_vaddr;
    paddr_t     xlat_paddr;
    int         errors = 0;
    int         checks = 0;
    integer     seed = 42;

    mmu_cp0_top mmu_cp0_top_inst (
        .clk               (clk),
        .rst_n             (rst_n),
        .wb_cyc_i          (wb_cyc),
        .wb_stb_i          (wb_stb),
        .wb_we_i           (wb_we),
        .wb_adr_i          (wb_adr),
        .wb_dat_i          (wb_dat_w),
        .wb_dat_o          (wb_dat_r),
        .wb_ack_o          (wb_ack),
        .hw_int_i          (hw_int),
        .exc_i             (exc),
        .exc_epc_i         (exc_epc),
        .exc_bd_i          (exc_bd),
        .exc_code_i        (exc_code),
        .exc_badvaddr_i    (exc_badvaddr),
        .eret_i            (eret),
        .tlbwi_i           (tlbwi),
        .irq_o             (irq),
        .user_mode_o       (user_mode),
        .exc_vector_o      (exc_vector),
        .xlat_req_i        (xlat_req),
        .xlat_vaddr_i      (xlat_vaddr),
        .xlat_valid_o      (xlat_valid),
        .xlat_paddr_o      (xlat_paddr),
        .xlat_hit_o        (xlat_hit),
        .xlat_page_valid_o (xlat_page_valid),
        .xlat_dirty_o      (xlat_dirty)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("Simulation finished: FAIL");
        $finish;
    end

    task automatic compare_value(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    // one classic cycle with the read data taken while ack is high
    task automatic wb_access(input reg_addr_t adr, input logic we, input word_t wdat,
                             output word_t rdat);
        int waited;
        waited = 0;
        @(posedge clk);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we <= we;
        wb_adr <= adr;
        wb_dat_w <= wdat;
        @(negedge clk);
        while (!wb_ack && waited < 16) begin
            @(negedge clk);
            waited++;
        end
        rdat = wb_dat_r;
        if (!wb_ack) begin
            errors++;
            $display("no ack from the slave for register %0d", adr);
        end
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we <= 1'b0;
    endtask

    task automatic program_entry(input logic [74:0] row);
        word_t ignored;
        wb_access(`CP0_INDEX, 1'b1, {28'b0, row[74:71]}, ignored);
        wb_access(`CP0_ENTRYHI, 1'b1, {row[70:52], 13'b0}, ignored);
        wb_access(`CP0_ENTRYLO0, 1'b1, {2'b0, row[51:28], 3'b0, row[27:26], 1'b0}, ignored);
        wb_access(`CP0_ENTRYLO1, 1'b1, {2'b0, row[25:2], 3'b0, row[1:0], 1'b0}, ignored);
        @(posedge clk);
        tlbwi <= 1'b1;
        @(posedge clk);
        tlbwi <= 1'b0;
    endtask

    // expected {hit, valid, dirty, paddr} where the lowest index wins among equal page pairs
    function automatic logic [38:0] tlb_model(word_t va);
        logic [38:0] res;
        logic [74:0] row;
        int best;
        res = '0;
        best = `TLB_ENTRIES;
        for (int i = 0; i < TLB_N; i++) begin
            row = TLB_TAB[i];
            if (row[70:52] == va[31:13] && int'(row[74:71]) < best) begin
                best = int'(row[74:71]);
                if (va[12]) begin
                    res = {1'b1, row[0], row[1], row[25:2], va[11:0]};
                end else begin
                    res = {1'b1, row[26], row[27], row[51:28], va[11:0]};
                end
            end
        end
        return res;
    endfunction

    initial begin : main
        word_t       rd, cnt, va;
        logic [31:0] pick;
        logic [38:0] exp;
        logic [38:0] exp_q [$];
        int          polls;
        rst_n <= 1'b0;
        {wb_cyc, wb_stb, wb_we, exc, exc_bd, eret, tlbwi, xlat_req} <= '0;
        wb_adr <= '0;
        wb_dat_w <= '0;
        hw_int <= '0;
        exc_epc <= '0;
        exc_badvaddr <= '0;
        exc_code <= '0;
        xlat_vaddr <= '0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        wb_access(`CP0_STATUS, 1'b0, '0, rd);
        compare_value("wb_dat_o[status]", 64'(rd), 64'h10);
        wb_access(`CP0_EBASE, 1'b0, '0, rd);
        compare_value("wb_dat_o[ebase]", 64'(rd), 64'h80000000);
        @(negedge clk);
        compare_value("irq_o", 64'(irq), 64'(0));
        compare_value("user_mode_o", 64'(user_mode), 64'(1));
        // general exceptions enter at EBase plus 0x180
        compare_value("exc_vector_o", 64'(exc_vector), 64'h80000180);

        for (int i = 0; i < REG_N; i++) begin
            wb_access(REG_TAB[i][68:64], 1'b1, REG_TAB[i][63:32], rd);
            wb_access(REG_TAB[i][68:64], 1'b0, '0, rd);
            compare_value($sformatf("wb_dat_o[reg %0d]", REG_TAB[i][68:64]),
                          64'(rd), 64'(REG_TAB[i][31:0]));
        end
        @(negedge clk);
        compare_value("exc_vector_o", 64'(exc_vector), 64'h92345180);

        // arm the timer a little ahead of the count just read
        wb_access(`CP0_STATUS, 1'b1, 32'h11, rd);
        wb_access(`CP0_COUNT, 1'b0, '0, cnt);
        wb_access(`CP0_COMPARE, 1'b1, cnt + 32'd40, rd);
        polls = 0;
        rd = '0;
        while (!rd[15] && polls < 100) begin
            wb_access(`CP0_CAUSE, 1'b0, '0, rd);
            polls++;
        end
        if (!rd[15]) begin
            errors++;
            $display("timer interrupt never appeared in Cause bit 15");
        end
        @(negedge clk);
        compare_value("irq_o", 64'(irq), 64'(1));
        wb_access(`CP0_COMPARE, 1'b1, '0, rd);
        wb_access(`CP0_CAUSE, 1'b0, '0, rd);
        compare_value("wb_dat_o[cause]", 64'(rd), 64'h0);
        @(negedge clk);
        compare_value("irq_o", 64'(irq), 64'(0));

        // a pending hardware line is masked from exception entry until eret
        @(posedge clk);
        hw_int <= 6'b000001;
        @(negedge clk);
        compare_value("irq_o", 64'(irq), 64'(1));
        @(posedge clk);
        exc <= 1'b1;
        exc_epc <= 32'h80001234;
        exc_badvaddr <= 32'hC0FFEE00;
        exc_bd <= 1'b1;
        exc_code <= 5'h0A;
        @(posedge clk);
        exc <= 1'b0;
        wb_access(`CP0_EPC, 1'b0, '0, rd);
        compare_value("wb_dat_o[epc]", 64'(rd), 64'h80001234);
        wb_access(`CP0_BADVADDR, 1'b0, '0, rd);
        compare_value("wb_dat_o[badvaddr]", 64'(rd), 64'hC0FFEE00);
        wb_access(`CP0_CAUSE, 1'b0, '0, rd);
        compare_value("wb_dat_o[cause]", 64'(rd), 64'h80000428);
        wb_access(`CP0_STATUS, 1'b0, '0, rd);
        compare_value("wb_dat_o[status]", 64'(rd), 64'h13);
        @(negedge clk);
        compare_value("irq_o", 64'(irq), 64'(0));
        @(posedge clk);
        eret <= 1'b1;
        @(posedge clk);
        eret <= 1'b0;
        @(negedge clk);
        compare_value("irq_o", 64'(irq), 64'(1));
        @(posedge clk);
        hw_int <= '0;

        for (int i = 0; i < TLB_N; i++) begin
            program_entry(TLB_TAB[i]);
        end
        repeat (2) @(posedge clk);

        // back-to-back lookups whose results show one cycle after each request
        for (int i = 0; i <= LOOKUPS; i++) begin
            @(posedge clk);
            if (i < LOOKUPS) begin
                pick = $random(seed);
                va = $random(seed);
                if (pick[0]) begin
                    va = {TLB_TAB[int'(pick[7:1]) % TLB_N][70:52], va[12:0]};
                end
                exp_q.push_back(tlb_model(va));
                xlat_req <= 1'b1;
                xlat_vaddr <= va;
            end else begin
                xlat_req <= 1'b0;
            end
            @(negedge clk);
            if (i > 0) begin
                exp = exp_q.pop_front();
                compare_value("xlat_valid_o", 64'(xlat_valid), 64'(1));
                compare_value("xlat_hit_o", 64'(xlat_hit), 64'(exp[38]));
                compare_value("xlat_page_valid_o", 64'(xlat_page_valid), 64'(exp[37]));
                compare_value("xlat_dirty_o", 64'(xlat_dirty), 64'(exp[36]));
                compare_value("xlat_paddr_o", 64'(xlat_paddr), 64'(exp[35:0]));
            end
        end
        @(negedge clk);
        compare_value("xlat_valid_o", 64'(xlat_valid), 64'(0));

        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: sim.f
+incdir+rtl
rtl/cp0_pkg.sv
rtl/tlb_wr_if.sv
rtl/cp0_regfile.sv
rtl/tlb_entry.sv
rtl/tlb_translate.sv
rtl/mmu_cp0_top.sv
verification/mmu_cp0_assert.sv
verification/mmu_cp0_tb.sv

// File: Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

# the run passes only if the log holds the pass message
test:
	verilator --binary --assert -Wno-fatal -f sim.f --top-module mmu_cp0_tb -Mdir obj_dir
	./obj_dir/Vmmu_cp0_tb | tee $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
